// File: ucpd_bmc_pkg.sv
package ucpd_bmc_pkg;

  // ------------------------------------------------------------------------
  // interval counting
  // ------------------------------------------------------------------------
  // width of every interval count and of the threshold
  localparam int UI_CNT_W = 11;
  // intermediate width for the threshold product, (3 * 2047) * 3 fits
  localparam int TH_PROD_W = UI_CNT_W + 4;

  typedef logic [UI_CNT_W-1:0]  ui_cnt_t;
  typedef logic [TH_PROD_W-1:0] th_prod_t;

  // counter saturates here, treated as line idle
  localparam ui_cnt_t UI_CNT_MAX = '1;

  // ------------------------------------------------------------------------
  // training
  // ------------------------------------------------------------------------
  // intervals A, B and C of the preamble
  localparam int TRN_NUM_IV = 3;
  // th = (A + B + C) * 3 >> 3, i.e. 2 UI * 3/8 = 3/4 UI
  localparam th_prod_t TH_MUL = 3;
  localparam int TH_SHIFT = 3;

  // bit 1 selects two-sample filter, bit 0 bypasses the filter
  typedef enum logic [1:0] {
    CC_FILT_3OF3   = 2'b00,
    CC_FILT_2OF3   = 2'b10,
    CC_FILT_BYPASS = 2'b01
  } cc_filt_e;

  typedef enum logic [1:0] {
    TRN_IDLE    = 2'b00,
    TRN_CAPTURE = 2'b01,
    TRN_LOCKED  = 2'b10
  } trn_state_e;

endpackage

// File: ucpd_cc_frontend.sv
`timescale 1ns/10ps

module ucpd_cc_frontend (
  input  logic                   ucpd_clk,
  input  logic                   ic_rst_n,
  input  logic                   cc_in,
  input  ucpd_bmc_pkg::cc_filt_e rxfilte,
  input  logic                   phy_rx_en,
  output logic                   iv_vld,
  output ucpd_bmc_pkg::ui_cnt_t  iv_len
);

  logic [1:0]            sync_q;
  logic                  cc_sync;
  logic                  hist_d0;
  logic                  hist_d1;
  logic                  filt_lvl;
  logic                  filt_q;
  logic                  filt_edge;
  logic                  armed;
  ucpd_bmc_pkg::ui_cnt_t iv_cnt;
  ucpd_bmc_pkg::ui_cnt_t cnt_inc;

  // ------------------------------------------------------------------------
  // two-flop synchronizer and sample history
  // ------------------------------------------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      sync_q  <= '0;
      hist_d0 <= 1'b0;
      hist_d1 <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], cc_in};
      hist_d0 <= cc_sync;
      hist_d1 <= hist_d0;
    end
  end

  assign cc_sync = sync_q[1];

  // ------------------------------------------------------------------------
  // glitch filter, old level held until samples agree
  // ------------------------------------------------------------------------
  always_comb begin
    case (rxfilte)
      ucpd_bmc_pkg::CC_FILT_BYPASS: filt_lvl = cc_sync;
      // two consecutive equal samples
      ucpd_bmc_pkg::CC_FILT_2OF3: filt_lvl = (cc_sync == hist_d0) ? cc_sync : filt_q;
      // three equal samples, also the fallback for the unused code
      default: filt_lvl = ((cc_sync == hist_d0) && (hist_d0 == hist_d1)) ? cc_sync : filt_q;
    endcase
  end

  // filt_q doubles as the edge reference
  assign filt_edge = filt_lvl ^ filt_q;
  // saturating increment, iv_len counts the edge cycle itself
  assign cnt_inc   = (iv_cnt == ucpd_bmc_pkg::UI_CNT_MAX) ? iv_cnt : iv_cnt + 1'b1;

  // ------------------------------------------------------------------------
  // edge register and interval counter
  // ------------------------------------------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      filt_q <= 1'b0;
      armed  <= 1'b0;
      iv_vld <= 1'b0;
      iv_cnt <= '0;
    end else begin
      filt_q <= filt_lvl;
      // first edge after enable only arms the count
      iv_vld <= filt_edge & armed & phy_rx_en;
      if (!phy_rx_en) begin
        armed  <= 1'b0;
        iv_cnt <= '0;
      end else if (filt_edge) begin
        armed  <= 1'b1;
        iv_cnt <= '0;
      end else begin
        iv_cnt <= cnt_inc;
      end
    end
  end

  // length sampled with the edge, valid with iv_vld
  always_ff @(posedge ucpd_clk) begin
    if (filt_edge) begin
      iv_len <= cnt_inc;
    end
  end

  // a strobed interval always spans at least one cycle
  a_iv_len_nonzero: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    iv_vld |-> (iv_len != '0));

endmodule

// File: ucpd_ui_trainer.sv
`timescale 1ns/10ps

module ucpd_ui_trainer (
  input  logic                  ucpd_clk,
  input  logic                  ic_rst_n,
  input  logic                  phy_rx_en,
  input  logic                  rx_idle_en,
  input  logic                  iv_vld,
  input  ucpd_bmc_pkg::ui_cnt_t iv_len,
  output ucpd_bmc_pkg::ui_cnt_t th_ui,
  output logic                  receive_en
);

  ucpd_bmc_pkg::trn_state_e state;
  logic [1:0]               iv_idx;
  ucpd_bmc_pkg::ui_cnt_t    iv_a;
  ucpd_bmc_pkg::ui_cnt_t    iv_b;
  logic                     rx_stop;
  logic                     iv_sat;
  logic                     last_iv;
  logic                     triple_ok;
  ucpd_bmc_pkg::th_prod_t   th_sum;
  ucpd_bmc_pkg::th_prod_t   th_div;
  ucpd_bmc_pkg::ui_cnt_t    th_calc;

  // receive stops on idle request or disabled phy
  assign rx_stop = rx_idle_en | ~phy_rx_en;
  // saturated interval is idle line, not preamble
  assign iv_sat  = (iv_len == ucpd_bmc_pkg::UI_CNT_MAX);
  assign last_iv = (iv_idx == 2'(ucpd_bmc_pkg::TRN_NUM_IV - 1));

  // ------------------------------------------------------------------------
  // triple check, C is the interval on the bus right now
  // ------------------------------------------------------------------------
  // A,B < C: started on a 1 (short, short, long)
  // A > B,C: started on a 0 (long, short, short)
  // B largest means the first half of a 1 was lost
  assign triple_ok = ((iv_a < iv_len) && (iv_b < iv_len)) ||
                     ((iv_a > iv_b) && (iv_a > iv_len));

  // sum of three intervals covers two UI
  assign th_sum  = ucpd_bmc_pkg::th_prod_t'(iv_a) + ucpd_bmc_pkg::th_prod_t'(iv_b) +
                   ucpd_bmc_pkg::th_prod_t'(iv_len);
  assign th_div  = (th_sum * ucpd_bmc_pkg::TH_MUL) >> ucpd_bmc_pkg::TH_SHIFT;
  // clamp to counter range
  assign th_calc = (th_div > ucpd_bmc_pkg::th_prod_t'(ucpd_bmc_pkg::UI_CNT_MAX)) ?
                   ucpd_bmc_pkg::UI_CNT_MAX : th_div[ucpd_bmc_pkg::UI_CNT_W-1:0];

  // ------------------------------------------------------------------------
  // training FSM
  // ------------------------------------------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      state      <= ucpd_bmc_pkg::TRN_IDLE;
      iv_idx     <= '0;
      receive_en <= 1'b0;
    end else if (rx_stop) begin
      state      <= ucpd_bmc_pkg::TRN_IDLE;
      iv_idx     <= '0;
      receive_en <= 1'b0;
    end else begin
      case (state)
        ucpd_bmc_pkg::TRN_IDLE: begin
          state  <= ucpd_bmc_pkg::TRN_CAPTURE;
          iv_idx <= '0;
        end
        ucpd_bmc_pkg::TRN_CAPTURE: begin
          if (iv_vld) begin
            if (iv_sat) begin
              // idle gap, start the triple over
              iv_idx <= '0;
            end else if (last_iv) begin
              iv_idx <= '0;
              // rejected triple just stays in capture
              if (triple_ok) begin
                state      <= ucpd_bmc_pkg::TRN_LOCKED;
                receive_en <= 1'b1;
              end
            end else begin
              iv_idx <= iv_idx + 1'b1;
            end
          end
        end
        // locked until stop
        ucpd_bmc_pkg::TRN_LOCKED: state <= ucpd_bmc_pkg::TRN_LOCKED;
        default: state <= ucpd_bmc_pkg::TRN_IDLE;
      endcase
    end
  end

  // interval store and threshold load
  always_ff @(posedge ucpd_clk) begin
    if ((state == ucpd_bmc_pkg::TRN_CAPTURE) && iv_vld && !rx_stop) begin
      if (iv_idx == 2'd0) begin
        iv_a <= iv_len;
      end
      if (iv_idx == 2'd1) begin
        iv_b <= iv_len;
      end
      if (last_iv && triple_ok && !iv_sat) begin
        th_ui <= th_calc;
      end
    end
  end

  a_rx_en_locked: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    receive_en == (state == ucpd_bmc_pkg::TRN_LOCKED));

  // a locked threshold of zero would decode everything as 0
  a_th_nonzero: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    receive_en |-> (th_ui != '0));

endmodule

// File: ucpd_bmc_decoder.sv
`timescale 1ns/10ps

module ucpd_bmc_decoder (
  input  logic                  ucpd_clk,
  input  logic                  ic_rst_n,
  input  logic                  receive_en,
  input  logic                  iv_vld,
  input  ucpd_bmc_pkg::ui_cnt_t iv_len,
  input  ucpd_bmc_pkg::ui_cnt_t th_ui,
  output logic                  rx_bit_vld,
  output logic                  rx_bit
);

  logic iv_take;
  logic long_iv;
  logic half_pend;
  logic bit_done;
  logic bit_val;

  // ------------------------------------------------------------------------
  // interval classification
  // ------------------------------------------------------------------------
  // intervals only count once the threshold is trained
  assign iv_take  = iv_vld & receive_en;
  // longer than 3/4 UI is a full-bit interval
  assign long_iv  = (iv_len > th_ui);
  // long interval closes a 0, second short one closes a 1
  assign bit_done = iv_take & (long_iv | half_pend);
  assign bit_val  = ~long_iv;

  // ------------------------------------------------------------------------
  // half-bit tracking and bit strobe
  // ------------------------------------------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      half_pend  <= 1'b0;
      rx_bit_vld <= 1'b0;
    end else begin
      rx_bit_vld <= bit_done;
      if (!receive_en) begin
        // drop any half bit left from before the lock
        half_pend <= 1'b0;
      end else if (iv_take) begin
        // short sets pending, anything that completes a bit clears it
        half_pend <= ~long_iv & ~half_pend;
      end
    end
  end

  // bit value rides with the strobe
  always_ff @(posedge ucpd_clk) begin
    if (bit_done) begin
      rx_bit <= bit_val;
    end
  end

  // a bit only comes from an interval taken while locked
  a_no_bit_unlocked: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    $rose(rx_bit_vld) |-> $past(receive_en));

endmodule

// File: ucpd_bmc_rx.sv
`timescale 1ns/10ps

module ucpd_bmc_rx (
  input  logic                   ucpd_clk,
  input  logic                   ic_rst_n,
  input  logic                   cc_in,
  input  ucpd_bmc_pkg::cc_filt_e rxfilte,
  input  logic                   phy_rx_en,
  input  logic                   rx_idle_en,
  output logic                   rx_bit_vld,
  output logic                   rx_bit,
  output logic                   receive_en
);

  // front end to trainer and decoder
  logic                  iv_vld;
  ucpd_bmc_pkg::ui_cnt_t iv_len;
  // trained threshold into the decoder
  ucpd_bmc_pkg::ui_cnt_t th_ui;

  // ------------------------------------------------------------------------
  // CC sync, filter and interval measurement
  // ------------------------------------------------------------------------
  ucpd_cc_frontend i_ucpd_cc_frontend (
    .ucpd_clk  (ucpd_clk),
    .ic_rst_n  (ic_rst_n),
    .cc_in     (cc_in),
    .rxfilte   (rxfilte),
    .phy_rx_en (phy_rx_en),
    .iv_vld    (iv_vld),
    .iv_len    (iv_len)
  );

  // preamble training, owns receive_en
  ucpd_ui_trainer i_ucpd_ui_trainer (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .phy_rx_en  (phy_rx_en),
    .rx_idle_en (rx_idle_en),
    .iv_vld     (iv_vld),
    .iv_len     (iv_len),
    .th_ui      (th_ui),
    .receive_en (receive_en)
  );

  // interval stream to bits
  ucpd_bmc_decoder i_ucpd_bmc_decoder (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .receive_en (receive_en),
    .iv_vld     (iv_vld),
    .iv_len     (iv_len),
    .th_ui      (th_ui),
    .rx_bit_vld (rx_bit_vld),
    .rx_bit     (rx_bit)
  );

endmodule

// File: tb_ucpd_bmc_rx.sv
`timescale 1ns/10ps

module tb_ucpd_bmc_rx;

  localparam int SEED_INIT   = 32'h105f4e07;
  localparam int NUM_FRAMES  = 12;
  localparam int PRE_BITS    = 16;
  localparam int PAY_BITS    = 40;
  localparam int HALF_UI_MIN = 6;
  localparam int HALF_UI_MAX = 40;
  localparam int DRAIN_CYC   = 10;
  localparam int SAT_LEN     = int'(ucpd_bmc_pkg::UI_CNT_MAX);
  // every bit at most two half-UI, plus lead, tail edges and gaps per frame
  localparam int TIMEOUT_CYC = NUM_FRAMES * ((PRE_BITS + PAY_BITS + 6) * 2 * HALF_UI_MAX + 100)
                               + 500;

  logic                   ucpd_clk;
  logic                   ic_rst_n;
  logic                   cc_in;
  ucpd_bmc_pkg::cc_filt_e rxfilte;
  logic                   phy_rx_en;
  logic                   rx_idle_en;
  logic                   rx_bit_vld;
  logic                   rx_bit;
  logic                   receive_en;

  int   seed;
  int   cyc;
  int   since_edge;
  logic cc_lvl;
  logic exp_q[$];
  logic mon_exp;
  // reference model state
  logic m_en;
  logic m_armed;
  logic m_locked;
  logic m_pend;
  int   m_idx;
  int   m_a;
  int   m_b;
  int   m_th;

  ucpd_bmc_rx i_ucpd_bmc_rx (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .cc_in      (cc_in),
    .rxfilte    (rxfilte),
    .phy_rx_en  (phy_rx_en),
    .rx_idle_en (rx_idle_en),
    .rx_bit_vld (rx_bit_vld),
    .rx_bit     (rx_bit),
    .receive_en (receive_en)
  );

  initial begin
    ucpd_clk = 1'b0;
    forever #5 ucpd_clk = ~ucpd_clk;
  end

  // ------------------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------------------
  task automatic check_bit(input logic act, input logic exp);
    if (act !== exp) begin
      $display("ERROR rx_bit: got 0x%0h expected 0x%0h", act, exp);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic check_rx_state(input logic act, input logic exp);
    if (act !== exp) begin
      $display("ERROR receive_en: got 0x%0h expected 0x%0h", act, exp);
      $display("test failed");
      $fatal(1);
    end
  endtask

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic tick();
    @(posedge ucpd_clk);
    since_edge++;
  endtask

  // ------------------------------------------------------------------------
  // reference model, one call per measured interval
  // ------------------------------------------------------------------------
  task automatic clear_model();
    m_locked = 1'b0;
    m_pend   = 1'b0;
    m_idx    = 0;
  endtask

  task automatic model_interval(input int len);
    int c;
    c = (len > SAT_LEN) ? SAT_LEN : len;
    if (!m_locked) begin
      // idle gap restarts the triple
      if (c == SAT_LEN) begin
        m_idx = 0;
      end else if (m_idx == 0) begin
        m_a   = c;
        m_idx = 1;
      end else if (m_idx == 1) begin
        m_b   = c;
        m_idx = 2;
      end else begin
        m_idx = 0;
        if (((m_a < c) && (m_b < c)) || ((m_a > m_b) && (m_a > c))) begin
          m_locked = 1'b1;
          m_th     = ((m_a + m_b + c) * 3) >> 3;
          m_pend   = 1'b0;
        end
      end
    end else if (c > m_th) begin
      exp_q.push_back(1'b0);
      m_pend = 1'b0;
    end else if (m_pend) begin
      exp_q.push_back(1'b1);
      m_pend = 1'b0;
    end else begin
      m_pend = 1'b1;
    end
  endtask

  task automatic set_rx_enable(input logic en);
    phy_rx_en <= en;
    m_en = en;
    if (!en) begin
      m_armed = 1'b0;
      clear_model();
    end
  endtask

  // ------------------------------------------------------------------------
  // line driver
  // ------------------------------------------------------------------------
  // hold the level for len cycles, then toggle
  task automatic drive_interval(input int len, input logic glitch);
    int i;
    for (i = 1; i < len; i++) begin
      tick();
      // one-cycle pulse, three cycles clear of either edge
      if (glitch && (i == 3)) cc_in <= ~cc_lvl;
      if (glitch && (i == 4)) cc_in <= cc_lvl;
    end
    tick();
    cc_lvl = ~cc_lvl;
    cc_in <= cc_lvl;
    // first edge after enable only arms
    if (m_en && m_armed) model_interval(since_edge);
    if (m_en) m_armed = 1'b1;
    since_edge = 0;
  endtask

  task automatic drive_bit(input logic b, input int half_ui, input logic glitch_ok);
    if (!b) begin
      drive_interval(2 * half_ui, glitch_ok && (rand_below(4) == 0));
    end else begin
      drive_interval(half_ui, glitch_ok && (rand_below(4) == 0));
      drive_interval(half_ui, glitch_ok && (rand_below(4) == 0));
    end
  endtask

  // last bit is out within a few cycles of its edge
  task automatic drain_bits();
    int n;
    n = 0;
    while ((exp_q.size() != 0) && (n < DRAIN_CYC)) begin
      tick();
      n++;
    end
    repeat (2) tick();
    if (exp_q.size() != 0) begin
      $display("%0d expected bits never appeared on rx_bit_vld", exp_q.size());
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic run_frame(input int idx);
    int   half_ui;
    int   ftype;
    int   i;
    logic glitch_ok;
    logic b;
    half_ui   = HALF_UI_MIN + rand_below(HALF_UI_MAX - HALF_UI_MIN + 1);
    ftype     = idx % 3;
    glitch_ok = ((idx / 3) % 3) != 2;
    // filter mode only changes with receive off
    set_rx_enable(1'b0);
    repeat (4) tick();
    case ((idx / 3) % 3)
      0: rxfilte <= ucpd_bmc_pkg::CC_FILT_3OF3;
      1: rxfilte <= ucpd_bmc_pkg::CC_FILT_2OF3;
      default: rxfilte <= ucpd_bmc_pkg::CC_FILT_BYPASS;
    endcase
    repeat (10) tick();
    set_rx_enable(1'b1);
    // idle level, then the start edge
    drive_interval(10, 1'b0);
    if (ftype == 2) begin
      // short, long, short gets rejected
      drive_interval(half_ui, 1'b0);
      drive_interval(2 * half_ui, 1'b0);
      drive_interval(half_ui, 1'b0);
    end
    // type 0 opens with a 0, the others with a 1
    for (i = 0; i < PRE_BITS; i++) begin
      b = ((i % 2) == 0) != (ftype == 0);
      drive_bit(b, half_ui, glitch_ok);
    end
    for (i = 0; i < PAY_BITS; i++) begin
      drive_bit(rand_below(2) == 1, half_ui, glitch_ok);
    end
    drain_bits();
    @(negedge ucpd_clk);
    check_rx_state(receive_en, m_locked);
    // stop by idle request or by disable
    tick();
    if ((idx % 2) == 0) begin
      rx_idle_en <= 1'b1;
      clear_model();
      tick();
      rx_idle_en <= 1'b0;
    end else begin
      set_rx_enable(1'b0);
    end
    repeat (3) tick();
    @(negedge ucpd_clk);
    check_rx_state(receive_en, 1'b0);
    // edges after the stop, none of them may decode
    drive_interval(2 * half_ui, 1'b0);
    drive_interval(2 * half_ui, 1'b0);
    drain_bits();
  endtask

  // ------------------------------------------------------------------------
  // bit monitor and watchdog
  // ------------------------------------------------------------------------
  always @(negedge ucpd_clk) begin
    if (ic_rst_n && rx_bit_vld) begin
      if (exp_q.size() == 0) begin
        $display("rx_bit_vld pulsed while the model expected no bit");
        $display("test failed");
        $fatal(1);
      end else begin
        mon_exp = exp_q.pop_front();
        check_bit(rx_bit, mon_exp);
      end
    end
  end

  initial begin
    cyc = 0;
    while (cyc < TIMEOUT_CYC) begin
      @(posedge ucpd_clk);
      cyc++;
    end
    $display("simulation ran past %0d cycles without finishing", TIMEOUT_CYC);
    $display("test failed");
    $fatal(1);
  end

  initial begin
    int f;
    cc_in      = 1'b0;
    rxfilte    = ucpd_bmc_pkg::CC_FILT_3OF3;
    phy_rx_en  = 1'b0;
    rx_idle_en = 1'b0;
    ic_rst_n   = 1'b0;
    seed       = SEED_INIT;
    since_edge = 0;
    cc_lvl     = 1'b0;
    m_en       = 1'b0;
    m_armed    = 1'b0;
    clear_model();
    repeat (8) @(posedge ucpd_clk);
    ic_rst_n <= 1'b1;
    // quiet line, nothing may train or decode
    set_rx_enable(1'b1);
    for (f = 0; f < 20; f++) begin
      tick();
      @(negedge ucpd_clk);
      check_rx_state(receive_en, 1'b0);
    end
    for (f = 0; f < NUM_FRAMES; f++) begin
      run_frame(f);
    end
    $display("test passed");
    $finish;
  end

endmodule

// File: ucpd_bmc_rx.f
ucpd_bmc_pkg.sv
ucpd_cc_frontend.sv
ucpd_ui_trainer.sv
ucpd_bmc_decoder.sv
ucpd_bmc_rx.sv
tb_ucpd_bmc_rx.sv

// File: run_sim.sh
#!/bin/sh
# build the BMC receive testbench with Verilator and run it
# exit status follows the simulation result

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
  --timescale 1ns/10ps \
  --top-module tb_ucpd_bmc_rx \
  -f ucpd_bmc_rx.f \
  -o sim_tb_ucpd_bmc_rx &&
./obj_dir/sim_tb_ucpd_bmc_rx || exit 1
